/* Makefile */
# Verilator flow for the binary32/binary16 format converter

VERILATOR  ?= verilator
TOP        ?= fcvt_tb
FILELIST   ?= project.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# Verdict comes from the log, a missing verdict counts as failure
sim: build
	$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation reported failures"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || { echo "Simulation ended without a verdict"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* include/fcvt_defines.svh */
/*
 * Format converter constants
 * Field widths and biases of binary32 and binary16, the internal
 * exponent and mantissa widths, the user tag width and the number
 * of register stages in the converter pipeline.
 */

`ifndef FCVT_DEFINES_SVH
`define FCVT_DEFINES_SVH

// ------------------------------------------------------------
// binary32 (single)
// ------------------------------------------------------------
`define FCVT_W32 32   // Total width
`define FCVT_E32 8    // Exponent bits
`define FCVT_M32 23   // Mantissa bits, no hidden bit
`define FCVT_B32 127  // Exponent bias

// ------------------------------------------------------------
// binary16 (half)
// ------------------------------------------------------------
`define FCVT_W16 16
`define FCVT_E16 5
`define FCVT_M16 10
`define FCVT_B16 15

// Internal datapath
`define FCVT_TAG_W 4   // User tag
`define FCVT_EXP_W 10  // Signed unbiased exponent, covers smallest half subnormal
`define FCVT_MAN_W 24  // Normalized mantissa incl. hidden bit

`define FCVT_STAGES 2  // Register stages from request to response

`endif

/* project.f */
+incdir+include
verilog/fcvt_pkg.sv
verilog/fcvt_classify.sv
verilog/fcvt_cast.sv
verilog/fcvt_round_select.sv
verilog/fcvt_stage.sv
verilog/fcvt_top.sv
verif/fcvt_assertions.sv
verif/fcvt_tb.sv

/* verif/fcvt_assertions.sv */
/*
 * Format converter protocol checks
 * Bound to the converter top level. Watches the response side for
 * reset behavior, stable data under back-pressure and busy level.
 */

`timescale 1ns/10ps

module fcvt_assertions (
  input logic              clk_i,
  input logic              rst_n_i,
  input fcvt_pkg::result_t rsp_i,
  input logic              out_valid_i,
  input logic              out_ready_i,
  input logic              busy_i
);

  // Output slot is cleared while reset is held
  a_reset_no_valid: assert property (@(posedge clk_i) !rst_n_i |-> !out_valid_i)
    else $error("out_valid_o high during reset");

  // ------------------------------------------------------------
  // Response held until taken
  // ------------------------------------------------------------
  a_stall_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      out_valid_i && !out_ready_i |=> out_valid_i && $stable(rsp_i))
    else $error("Stalled response changed before it was accepted");

  // A new response needs something in flight one cycle earlier
  a_busy_covers_out: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $rose(out_valid_i) |-> $past(busy_i))
    else $error("Response appeared while busy_o was low");

endmodule

bind fcvt_top fcvt_assertions u_assertions (
  .clk_i       ( clk_i       ),
  .rst_n_i     ( rst_n_i     ),
  .rsp_i       ( rsp_o       ),
  .out_valid_i ( out_valid_o ),
  .out_ready_i ( out_ready_i ),
  .busy_i      ( busy_o      )
);

/* verif/fcvt_tb.sv */
/*
 * Format converter testbench
 * Drives widening, narrowing, special values and back-pressure
 * traffic into the converter. Expected results come from an integer
 * reference model and are checked in order from a scoreboard queue.
 */

`timescale 1ns/10ps
`include "fcvt_defines.svh"

module fcvt_tb;

  localparam int N_WIDEN   = 200;
  localparam int N_NARROW  = 500;
  localparam int N_SPECIAL = 24;
  localparam int N_BP      = 300;
  localparam int N_OPS     = N_WIDEN + N_NARROW + N_SPECIAL + N_BP;
  localparam longint TIMEOUT_NS = (longint'(N_OPS) * 40 + 200) * 20;  // Per op budget plus reset

  typedef struct packed {
    fcvt_pkg::result_t rsp;
    logic [31:0]       acc_cycle;  // Edge count at accept
    logic              timed;      // Latency is checked
  } expect_t;

  logic               clk_i = 1'b0;
  logic               rst_n_i;
  fcvt_pkg::request_t req_i;
  logic               in_valid_i;
  logic               in_ready_o;
  fcvt_pkg::result_t  rsp_o;
  logic               out_valid_o;
  logic               out_ready_i;
  logic               busy_o;

  logic [31:0]            lfsr = 32'hbdf5ef1d;
  logic [`FCVT_TAG_W-1:0] next_tag = '0;
  logic                   stall_mode = 1'b0;
  int unsigned            cycle = 0;
  expect_t                expected_q[$];
  int                     result_errors = 0;
  int                     status_errors = 0;
  int                     timing_errors = 0;
  int                     other_errors = 0;

  fcvt_top fcvt_top_i (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .req_i       ( req_i       ),
    .in_valid_i  ( in_valid_i  ),
    .in_ready_o  ( in_ready_o  ),
    .rsp_o       ( rsp_o       ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i ),
    .busy_o      ( busy_o      )
  );

  always #10 clk_i = ~clk_i;  // 20 ns period

  always @(posedge clk_i) cycle <= cycle + 1;

  // ------------------------------------------------------------
  // Random source, one LFSR step per bit
  // ------------------------------------------------------------
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);  // x^32+x^22+x^2+x+1
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic fcvt_pkg::roundmode_e mode_of(input int k);
    return fcvt_pkg::roundmode_e'(3'(k % 5));
  endfunction

  // Single operand with exponent mostly near the half range
  function automatic logic [31:0] rand_single(input int k);
    logic [31:0] w;
    w = rand_bits(32);
    if (k % 4 != 0) w[30:23] = 8'd100 + 8'(rand_bits(6));  // Subnormal to overflow
    return w;
  endfunction

  // ------------------------------------------------------------
  // Reference converter, integer arithmetic on the IEEE fields
  // ------------------------------------------------------------
  function automatic fcvt_pkg::result_t ref_convert(input fcvt_pkg::request_t req);
    fcvt_pkg::result_t res;
    logic [15:0] h;
    logic [23:0] sig;
    logic [63:0] wide;
    logic [14:0] mag;
    logic        s;
    logic        r;
    logic        st;
    logic        inc;
    logic        ovf;
    int          eh;
    int          sh;
    int          msb;
    res.tag    = req.tag;
    res.status = '0;
    if (req.op == fcvt_pkg::H2F) begin
      h = req.operand[15:0];
      s = h[15];
      if (req.operand[31:16] != 16'hffff) begin
        res.result = 32'h7fc00000;  // Bad box reads as quiet NaN
      end else if (h[14:10] == 5'h1f && h[9:0] != 0) begin
        res.result    = 32'h7fc00000;
        res.status.NV = ~h[9];
      end else if (h[14:0] == 0) begin
        res.result = {s, 31'd0};
      end else if (h[14:10] == 5'h1f) begin
        res.result = {s, 8'hff, 23'd0};
      end else if (h[14:10] == 0) begin
        msb = 0;
        for (int i = 0; i < 10; i++) begin
          if (h[i]) msb = i;
        end
        wide       = 64'(h[9:0]) << (23 - msb);  // Leading one lands on the hidden bit
        res.result = {s, 8'(msb + 103), wide[22:0]};
      end else begin
        res.result = {s, 8'(h[14:10]) + 8'd112, h[9:0], 13'd0};
      end
    end else begin
      s = req.operand[31];
      if (req.operand[30:23] == 8'hff && req.operand[22:0] != 0) begin
        res.result    = 32'hffff7e00;
        res.status.NV = ~req.operand[22];
      end else if (req.operand[30:0] == 0) begin
        res.result = {16'hffff, s, 15'd0};
      end else begin
        sig = {req.operand[30:23] != 0, req.operand[22:0]};
        eh  = (req.operand[30:23] == 0) ? -111 : int'(req.operand[30:23]) - 112;
        ovf = (req.operand[30:23] == 8'hff) || (eh >= 31);
        if (ovf) begin
          mag = 15'h7bff;  // Max finite, rounding decides
          r   = 1'b1;
          st  = 1'b1;
        end else if (eh >= 1) begin
          mag = {5'(eh), sig[22:13]};
          r   = sig[12];
          st  = |sig[11:0];
        end else begin
          sh   = (14 - eh > 30) ? 30 : 14 - eh;  // Value in units of the smallest subnormal
          wide = 64'(sig);
          mag  = 15'(wide >> sh);
          r    = wide[sh-1];
          st   = (wide & ((64'd1 << (sh - 1)) - 64'd1)) != 0;
        end
        case (req.rnd_mode)
          fcvt_pkg::RNE: inc = r & (st | mag[0]);
          fcvt_pkg::RTZ: inc = 1'b0;
          fcvt_pkg::RDN: inc = (r | st) & s;
          fcvt_pkg::RUP: inc = (r | st) & ~s;
          default:       inc = r;
        endcase
        mag           = mag + 15'(inc);
        res.status.OF = (req.operand[30:23] != 8'hff) && (ovf || mag[14:10] == 5'h1f);
        res.status.UF = (mag[14:10] == 0) && (r || st);
        res.status.NX = r || st || res.status.OF;
        res.result    = {16'hffff, s, mag};
      end
    end
    return res;
  endfunction

  // ------------------------------------------------------------
  // Compare tasks
  // ------------------------------------------------------------
  task automatic check_result(input fcvt_pkg::result_t got, input fcvt_pkg::result_t exp);
    if (got.result !== exp.result || got.tag !== exp.tag) begin
      result_errors++;
      $display("[FAIL] %0t: result %h tag %0d, expected %h tag %0d",
               $time, got.result, got.tag, exp.result, exp.tag);
    end
  endtask

  task automatic check_status(input fcvt_pkg::status_t got, input fcvt_pkg::status_t exp);
    if (got !== exp) begin
      status_errors++;
      $display("[FAIL] %0t: flags NV/OF/UF/NX %b, expected %b", $time, got, exp);
    end
  endtask

  task automatic check_level(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      other_errors++;
      $display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Scoreboard fill on every accepted request
  always @(posedge clk_i) begin : accept_monitor
    expect_t e;
    if (rst_n_i && in_valid_i && in_ready_o) begin
      e.rsp       = ref_convert(req_i);
      e.acc_cycle = cycle;
      e.timed     = ~stall_mode;
      expected_q.push_back(e);
    end
  end

  always @(posedge clk_i) begin : compare
    expect_t e;
    if (rst_n_i && out_valid_o && out_ready_i) begin
      if (expected_q.size() == 0) begin
        other_errors++;
        $display("Response with tag %0d arrived with no request outstanding", rsp_o.tag);
      end else begin
        e = expected_q.pop_front();
        check_result(rsp_o, e.rsp);
        check_status(rsp_o.status, e.rsp.status);
        if (e.timed && cycle != e.acc_cycle + 2) begin
          timing_errors++;
          $display("[FAIL] %0t: tag %0d took %0d cycles, expected 2",
                   $time, rsp_o.tag, cycle - e.acc_cycle);
        end
      end
    end
  end

  // ------------------------------------------------------------
  // Drivers, all on the falling edge
  // ------------------------------------------------------------
  task automatic drive_out_ready();
    out_ready_i = stall_mode ? (rand_bits(2) != 0) : 1'b1;  // 3 of 4 cycles when stalling
  endtask

  task automatic send(input fcvt_pkg::op_e op, input logic [31:0] operand,
                      input fcvt_pkg::roundmode_e mode);
    @(negedge clk_i);
    req_i.operand  = operand;
    req_i.op       = op;
    req_i.rnd_mode = mode;
    req_i.tag      = next_tag;
    in_valid_i     = 1'b1;
    drive_out_ready();
    @(posedge clk_i);
    while (!in_ready_o) begin
      @(negedge clk_i);
      drive_out_ready();
      @(posedge clk_i);
    end
    next_tag++;
  endtask

  task automatic drain();
    @(negedge clk_i);
    in_valid_i = 1'b0;
    drive_out_ready();
    while (busy_o) begin
      @(negedge clk_i);
      drive_out_ready();
    end
  endtask

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("Timeout: the converter stopped responding before all requests finished");
    $display("TEST FAILED");
    $finish;
  end

  initial begin : stimulus
    logic [15:0] h;
    rst_n_i     = 1'b0;
    req_i       = '0;
    in_valid_i  = 1'b0;
    out_ready_i = 1'b1;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);
    check_level(in_ready_o, 1'b1, "in_ready_o after reset");
    check_level(out_valid_o, 1'b0, "out_valid_o after reset");
    check_level(busy_o, 1'b0, "busy_o after reset");

    // Widening, every fourth operand subnormal or zero
    for (int i = 0; i < N_WIDEN; i++) begin
      h = 16'(rand_bits(16));
      if (i % 4 == 0) h[14:10] = '0;
      send(fcvt_pkg::H2F, {16'hffff, h}, mode_of(i));
    end
    drain();

    // Narrowing under all modes
    for (int i = 0; i < N_NARROW; i++) begin
      send(fcvt_pkg::F2H, rand_single(i), mode_of(i));
    end
    drain();

    // Special values
    send(fcvt_pkg::F2H, 32'h00000000, fcvt_pkg::RNE);
    send(fcvt_pkg::F2H, 32'h80000000, fcvt_pkg::RTZ);
    send(fcvt_pkg::F2H, 32'h7f800000, fcvt_pkg::RNE);
    send(fcvt_pkg::F2H, 32'hff800000, fcvt_pkg::RNE);
    send(fcvt_pkg::F2H, 32'h7fc00000, fcvt_pkg::RNE);  // Quiet
    send(fcvt_pkg::F2H, 32'h7f800001, fcvt_pkg::RNE);  // Signalling
    send(fcvt_pkg::F2H, 32'h477ff000, fcvt_pkg::RNE);  // Tie just above max finite
    send(fcvt_pkg::H2F, 32'hffff0000, fcvt_pkg::RNE);
    send(fcvt_pkg::H2F, 32'hffff8000, fcvt_pkg::RNE);
    send(fcvt_pkg::H2F, 32'hffff7c00, fcvt_pkg::RNE);
    send(fcvt_pkg::H2F, 32'hfffffc00, fcvt_pkg::RNE);
    send(fcvt_pkg::H2F, 32'hffff7e00, fcvt_pkg::RNE);
    send(fcvt_pkg::H2F, 32'hffff7c01, fcvt_pkg::RNE);
    send(fcvt_pkg::H2F, 32'h00003c00, fcvt_pkg::RNE);  // Unboxed 1.0
    for (int k = 0; k < 5; k++) begin
      send(fcvt_pkg::F2H, 32'h47800000, mode_of(k));   // 65536, overflows half
      send(fcvt_pkg::F2H, 32'hc7800000, mode_of(k));
    end
    drain();

    // Back-pressure with mixed directions
    stall_mode = 1'b1;
    for (int i = 0; i < N_BP; i++) begin
      if (rand_bits(1) != 0) begin
        send(fcvt_pkg::H2F, {16'hffff, 16'(rand_bits(16))}, mode_of(i));
      end else begin
        send(fcvt_pkg::F2H, rand_single(i), mode_of(i));
      end
    end
    drain();
    stall_mode  = 1'b0;
    out_ready_i = 1'b1;

    if (expected_q.size() != 0) begin
      other_errors++;
      $display("%0d requests never produced a response", expected_q.size());
    end
    $display("Errors: result %0d, flags %0d, latency %0d, other %0d",
             result_errors, status_errors, timing_errors, other_errors);
    if (result_errors + status_errors + timing_errors + other_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* verilog/fcvt_cast.sv */
/*
 * Format converter execute stage
 * Rebiases the exponent for the destination format. Narrowing
 * saturates overflows and denormalizes tiny values, producing the
 * half magnitude with round and sticky bits. Widening is exact and
 * builds the single magnitude directly.
 */

`timescale 1ns/10ps
`include "fcvt_defines.svh"

module fcvt_cast (
  input  fcvt_pkg::decoded_t dec_i,
  output fcvt_pkg::cast_t    cast_o
);

  localparam int unsigned PRE_W   = `FCVT_MAN_W + `FCVT_M16 + 1;  // Mantissa plus shift room
  localparam int unsigned SHAMT_W = $clog2(`FCVT_M16 + 2);
  localparam logic signed [`FCVT_EXP_W-1:0] BIAS16    = `FCVT_B16;
  localparam logic signed [`FCVT_EXP_W-1:0] BIAS32    = `FCVT_B32;
  localparam logic signed [`FCVT_EXP_W-1:0] MAX_EXP16 = (1 << `FCVT_E16) - 1;  // Inf exponent
  localparam logic signed [`FCVT_EXP_W-1:0] MIN_EXP16 = -`FCVT_M16;

  logic signed [`FCVT_EXP_W-1:0] dst_exp16;
  logic signed [`FCVT_EXP_W-1:0] dst_exp32;
  logic [`FCVT_E16-1:0]          final_exp16;
  logic [`FCVT_M16-1:0]          final_man16;
  logic [PRE_W-1:0]              pre_mant;
  logic [PRE_W-1:0]              dst_mant;
  logic [SHAMT_W-1:0]            shamt;      // Denormalization shift
  logic                          rnd16;
  logic                          stk16;
  logic                          of_before;
  logic                          uf_before;
  logic [`FCVT_W32-2:0]          abs32;

  // Rebias for both destinations
  assign dst_exp16 = dec_i.exponent + BIAS16;
  assign dst_exp32 = dec_i.exponent + BIAS32;

  // ------------------------------------------------------------
  // Narrowing adjustments
  // ------------------------------------------------------------
  always_comb begin : narrow_adjust
    final_exp16 = dst_exp16[`FCVT_E16-1:0];  // Lower bits as is
    pre_mant    = {dec_i.mantissa, {(`FCVT_M16+1){1'b0}}};
    shamt       = '0;
    of_before   = 1'b0;
    uf_before   = 1'b0;
    if ((dst_exp16 >= MAX_EXP16) || dec_i.info.is_inf) begin
      final_exp16 = {{(`FCVT_E16-1){1'b1}}, 1'b0};  // Largest normal
      pre_mant    = '1;                             // Max mantissa, R and S set
      of_before   = 1'b1;
    end else if (dst_exp16 < 1) begin
      final_exp16 = '0;
      uf_before   = 1'b1;
      if (dst_exp16 >= MIN_EXP16) begin
        shamt = SHAMT_W'(1 - dst_exp16);
      end else begin
        // Below half the smallest subnormal, everything lands in sticky
        pre_mant = {{(PRE_W-1){1'b0}}, |dec_i.mantissa};
      end
    end
  end

  assign dst_mant = pre_mant >> shamt;

  // Drop hidden bit, keep mantissa and round bit
  assign {final_man16, rnd16} = dst_mant[PRE_W-2 -: `FCVT_M16+1];
  assign stk16                = |dst_mant[`FCVT_MAN_W-2:0];

  // Widening never rounds, infinity needs its own exponent
  assign abs32 = dec_i.info.is_inf
               ? {{`FCVT_E32{1'b1}}, {`FCVT_M32{1'b0}}}
               : {dst_exp32[`FCVT_E32-1:0], dec_i.mantissa[`FCVT_M32-1:0]};

  always_comb begin : pack_cast
    cast_o.info     = dec_i.info;
    cast_o.sign     = dec_i.sign;
    cast_o.op       = dec_i.op;
    cast_o.rnd_mode = dec_i.rnd_mode;
    cast_o.tag      = dec_i.tag;
    if (dec_i.op == fcvt_pkg::F2H) begin
      cast_o.magnitude  = {{(`FCVT_W32-`FCVT_W16){1'b0}}, final_exp16, final_man16};
      cast_o.round_bit  = rnd16;
      cast_o.sticky_bit = stk16;
      cast_o.of_before  = of_before;
      cast_o.uf_before  = uf_before;
    end else begin
      cast_o.magnitude  = abs32;
      cast_o.round_bit  = 1'b0;
      cast_o.sticky_bit = 1'b0;
      cast_o.of_before  = 1'b0;
      cast_o.uf_before  = 1'b0;
    end
  end

endmodule

/* verilog/fcvt_classify.sv */
/*
 * Format converter decode stage
 * Picks the source format by op, checks NaN-boxing of half operands
 * and classifies the operand. Half subnormals are renormalized with
 * a leading zero count so the execute stage sees a normal mantissa.
 */

`timescale 1ns/10ps
`include "fcvt_defines.svh"

module fcvt_classify (
  input  fcvt_pkg::request_t req_i,
  output fcvt_pkg::decoded_t dec_o
);

  localparam int unsigned LZC_W = $clog2(`FCVT_M16 + 2);  // Counts 0 to M16+1
  localparam logic signed [`FCVT_EXP_W-1:0] BIAS32 = `FCVT_B32;
  localparam logic signed [`FCVT_EXP_W-1:0] BIAS16 = `FCVT_B16;

  logic [`FCVT_E32-1:0]          exp32;
  logic [`FCVT_M32-1:0]          man32;
  logic [`FCVT_E16-1:0]          exp16;
  logic [`FCVT_M16-1:0]          man16;
  logic                          boxed;
  logic                          exp_zero;
  logic                          exp_ones;
  logic                          man_zero;
  logic                          quiet_bit;  // Mantissa MSB
  fcvt_pkg::fp_info_t            info;
  logic [`FCVT_M16:0]            enc_man16;  // With hidden bit
  logic [LZC_W-1:0]              lz_cnt;
  logic [`FCVT_M16:0]            norm_man16;
  logic signed [`FCVT_EXP_W-1:0] exp_ub32;
  logic signed [`FCVT_EXP_W-1:0] exp_ub16;

  assign exp32 = req_i.operand[`FCVT_W32-2 -: `FCVT_E32];
  assign man32 = req_i.operand[`FCVT_M32-1:0];
  assign exp16 = req_i.operand[`FCVT_W16-2 -: `FCVT_E16];
  assign man16 = req_i.operand[`FCVT_M16-1:0];

  // Single operands are always boxed, halves need ones above
  assign boxed = (req_i.op == fcvt_pkg::F2H) | (&req_i.operand[`FCVT_W32-1:`FCVT_W16]);

  always_comb begin : field_flags
    if (req_i.op == fcvt_pkg::F2H) begin
      exp_zero  = ~|exp32;
      exp_ones  = &exp32;
      man_zero  = ~|man32;
      quiet_bit = man32[`FCVT_M32-1];
    end else begin
      exp_zero  = ~|exp16;
      exp_ones  = &exp16;
      man_zero  = ~|man16;
      quiet_bit = man16[`FCVT_M16-1];
    end
  end

  // ------------------------------------------------------------
  // Classification
  // ------------------------------------------------------------
  assign info.is_zero       = boxed & exp_zero & man_zero;
  assign info.is_subnormal  = boxed & exp_zero & ~man_zero;
  assign info.is_normal     = boxed & ~exp_zero & ~exp_ones;
  assign info.is_inf        = boxed & exp_ones & man_zero;
  assign info.is_nan        = ~boxed | (exp_ones & ~man_zero);  // Unboxed reads as qNaN
  assign info.is_signalling = boxed & exp_ones & ~man_zero & ~quiet_bit;
  assign info.is_boxed      = boxed;

  // Leading zero count over the half mantissa
  assign enc_man16 = {info.is_normal, man16};

  always_comb begin : lzc16
    lz_cnt = LZC_W'(`FCVT_M16 + 1);  // All zero
    for (int i = 0; i <= `FCVT_M16; i++) begin
      if (enc_man16[i]) lz_cnt = LZC_W'(`FCVT_M16 - i);  // Highest set bit wins
    end
  end

  assign norm_man16 = enc_man16 << lz_cnt;

  // Unbias, subnormals use exponent 1 and half ones shift left
  assign exp_ub32 = $signed({2'b00, exp32})
                  + $signed({{(`FCVT_EXP_W-1){1'b0}}, info.is_subnormal})
                  - BIAS32;
  assign exp_ub16 = $signed({{(`FCVT_EXP_W-`FCVT_E16){1'b0}}, exp16})
                  + $signed({{(`FCVT_EXP_W-1){1'b0}}, info.is_subnormal})
                  - $signed({{(`FCVT_EXP_W-LZC_W){1'b0}}, lz_cnt})
                  - BIAS16;

  always_comb begin : pack_decoded
    dec_o.info     = info;
    dec_o.op       = req_i.op;
    dec_o.rnd_mode = req_i.rnd_mode;
    dec_o.tag      = req_i.tag;
    if (req_i.op == fcvt_pkg::F2H) begin
      dec_o.sign     = req_i.operand[`FCVT_W32-1];
      dec_o.exponent = exp_ub32;
      dec_o.mantissa = {info.is_normal, man32};  // Single subnormals stay as they are
    end else begin
      dec_o.sign     = req_i.operand[`FCVT_W16-1];
      dec_o.exponent = exp_ub16;
      dec_o.mantissa = {norm_man16, {(`FCVT_MAN_W-`FCVT_M16-1){1'b0}}};  // Left aligned
    end
  end

endmodule

/* verilog/fcvt_pkg.sv */
/*
 * Format converter shared types
 * Rounding mode and direction encodings, status flags, operand
 * classification and the payload structs that move between the
 * decode, execute and result stages.
 */

`include "fcvt_defines.svh"

package fcvt_pkg;

  // Same encoding as the RISC-V frm field
  typedef enum logic [2:0] {
    RNE = 3'b000,
    RTZ = 3'b001,
    RDN = 3'b010,
    RUP = 3'b011,
    RMM = 3'b100
  } roundmode_e;

  typedef enum logic {
    F2H = 1'b0,  // binary32 to binary16
    H2F = 1'b1   // binary16 to binary32
  } op_e;

  typedef struct packed {
    logic NV;  // Invalid
    logic OF;  // Overflow
    logic UF;  // Underflow
    logic NX;  // Inexact
  } status_t;

  typedef struct packed {
    logic is_zero;
    logic is_subnormal;
    logic is_normal;
    logic is_inf;
    logic is_nan;
    logic is_signalling;
    logic is_boxed;  // Half operand properly NaN-boxed
  } fp_info_t;

  // ------------------------------------------------------------
  // Stage payloads
  // ------------------------------------------------------------
  typedef struct packed {
    logic [`FCVT_W32-1:0]   operand;  // Half sits in the low 16 bits
    op_e                    op;
    roundmode_e             rnd_mode;
    logic [`FCVT_TAG_W-1:0] tag;
  } request_t;

  typedef struct packed {
    logic                          sign;
    logic signed [`FCVT_EXP_W-1:0] exponent;  // Unbiased
    logic [`FCVT_MAN_W-1:0]        mantissa;  // Hidden bit at MSB
    fp_info_t                      info;
    op_e                           op;
    roundmode_e                    rnd_mode;
    logic [`FCVT_TAG_W-1:0]        tag;
  } decoded_t;

  typedef struct packed {
    logic [`FCVT_W32-2:0]   magnitude;   // {exp, man} of destination, right aligned
    logic                   round_bit;
    logic                   sticky_bit;
    logic                   of_before;   // Overflow before rounding
    logic                   uf_before;   // Tiny before rounding
    fp_info_t               info;
    logic                   sign;
    op_e                    op;
    roundmode_e             rnd_mode;
    logic [`FCVT_TAG_W-1:0] tag;
  } cast_t;

  typedef struct packed {
    logic [`FCVT_W32-1:0]   result;  // Half results NaN-boxed
    status_t                status;
    logic [`FCVT_TAG_W-1:0] tag;
  } result_t;

endpackage

/* verilog/fcvt_round_select.sv */
/*
 * Format converter result stage
 * Rounds narrowed magnitudes by mode, classifies the rounded value
 * for overflow and underflow, picks special results for zeros and
 * NaNs and returns the flags with a NaN-boxed half result.
 */

`timescale 1ns/10ps
`include "fcvt_defines.svh"

module fcvt_round_select (
  input  fcvt_pkg::cast_t   cast_i,
  output fcvt_pkg::result_t rsp_o
);

  localparam int unsigned ABS16_W = `FCVT_W16 - 1;
  localparam logic [`FCVT_W32-`FCVT_W16-1:0] BOX = '1;
  localparam logic [`FCVT_W16-1:0] QNAN16 =
      {1'b0, {`FCVT_E16{1'b1}}, 1'b1, {(`FCVT_M16-1){1'b0}}};
  localparam logic [`FCVT_W32-1:0] QNAN32 =
      {1'b0, {`FCVT_E32{1'b1}}, 1'b1, {(`FCVT_M32-1){1'b0}}};

  logic [ABS16_W-1:0]   abs16;
  logic [ABS16_W-1:0]   rounded16;
  logic                 round_up;
  logic                 inexact;
  logic                 of_after;
  logic                 uf_after;
  logic                 overflow;
  logic                 special;
  logic [`FCVT_W32-1:0] regular_res;
  logic [`FCVT_W32-1:0] special_res;
  fcvt_pkg::status_t    regular_st;
  fcvt_pkg::status_t    special_st;

  assign abs16   = cast_i.magnitude[ABS16_W-1:0];
  assign inexact = cast_i.round_bit | cast_i.sticky_bit;

  // ------------------------------------------------------------
  // Rounding, half destination only
  // ------------------------------------------------------------
  always_comb begin : round_decision
    case (cast_i.rnd_mode)
      fcvt_pkg::RNE: round_up = cast_i.round_bit & (cast_i.sticky_bit | abs16[0]);  // Ties even
      fcvt_pkg::RTZ: round_up = 1'b0;
      fcvt_pkg::RDN: round_up = inexact & cast_i.sign;   // Away from zero if negative
      fcvt_pkg::RUP: round_up = inexact & ~cast_i.sign;
      fcvt_pkg::RMM: round_up = cast_i.round_bit;        // Ties away
      default:       round_up = 1'b0;
    endcase
  end

  // Carry may ripple into the exponent
  assign rounded16 = abs16 + ABS16_W'(round_up);

  always_comb begin : post_round
    if (cast_i.op == fcvt_pkg::F2H) begin
      of_after    = &rounded16[ABS16_W-1 -: `FCVT_E16];
      uf_after    = ~|rounded16[ABS16_W-1 -: `FCVT_E16];
      regular_res = {BOX, cast_i.sign, rounded16};
      special_res = cast_i.info.is_zero ? {BOX, cast_i.sign, {ABS16_W{1'b0}}}
                                        : {BOX, QNAN16};
    end else begin
      of_after    = &cast_i.magnitude[`FCVT_W32-2 -: `FCVT_E32];
      uf_after    = ~|cast_i.magnitude[`FCVT_W32-2 -: `FCVT_E32];
      regular_res = {cast_i.sign, cast_i.magnitude};  // Exact
      special_res = cast_i.info.is_zero ? {cast_i.sign, {(`FCVT_W32-1){1'b0}}} : QNAN32;
    end
  end

  // Infinity inputs are not an overflow
  assign overflow = ~cast_i.info.is_inf & (cast_i.of_before | of_after);

  assign regular_st.NV = 1'b0;
  assign regular_st.OF = overflow;
  assign regular_st.UF = cast_i.uf_before & uf_after & inexact;  // Tiny after rounding
  assign regular_st.NX = inexact | overflow;

  // Zeros, NaNs and unboxed halves bypass the regular path
  assign special    = cast_i.info.is_zero | cast_i.info.is_nan | ~cast_i.info.is_boxed;
  assign special_st = '{NV: cast_i.info.is_signalling, default: 1'b0};

  assign rsp_o.result = special ? special_res : regular_res;
  assign rsp_o.status = special ? special_st : regular_st;
  assign rsp_o.tag    = cast_i.tag;

endmodule

/* verilog/fcvt_stage.sv */
/*
 * Elastic pipeline register
 * One valid/ready slot for any payload type. Accepts when empty
 * or when the downstream side takes the current entry.
 */

`timescale 1ns/10ps

module fcvt_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  // Upstream
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  // Downstream
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  logic     valid_q;
  payload_t data_q;

  assign ready_o = ~valid_q | ready_i;  // Empty or draining

  always_ff @(posedge clk_i or negedge rst_n_i) begin : valid_reg
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  // Load only on accept
  always_ff @(posedge clk_i) begin : data_reg
    if (valid_i && ready_o) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

/* verilog/fcvt_top.sv */
/*
 * Floating-point format converter
 * binary32 to binary16 and back with IEEE rounding and flags.
 * Decode, register, execute and round, register. Fixed latency of
 * two stages with valid/ready back-pressure.
 */

`timescale 1ns/10ps

module fcvt_top (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // Request side
  input  fcvt_pkg::request_t req_i,
  input  logic               in_valid_i,
  output logic               in_ready_o,
  // Response side
  output fcvt_pkg::result_t  rsp_o,
  output logic               out_valid_o,
  input  logic               out_ready_i,
  // Something in flight
  output logic               busy_o
);

  fcvt_pkg::decoded_t dec_d;
  fcvt_pkg::decoded_t dec_q;
  fcvt_pkg::cast_t    cast;
  fcvt_pkg::result_t  rsp_d;
  logic               s0_valid;
  logic               s0_ready;  // Stage 1 can take data

  fcvt_classify u_classify (
    .req_i ( req_i ),
    .dec_o ( dec_d )
  );

  // ------------------------------------------------------------
  // Stage 0 after decode
  // ------------------------------------------------------------
  fcvt_stage #(
    .payload_t ( fcvt_pkg::decoded_t )
  ) u_stage0 (
    .clk_i   ( clk_i      ),
    .rst_n_i ( rst_n_i    ),
    .valid_i ( in_valid_i ),
    .ready_o ( in_ready_o ),
    .data_i  ( dec_d      ),
    .valid_o ( s0_valid   ),
    .ready_i ( s0_ready   ),
    .data_o  ( dec_q      )
  );

  fcvt_cast u_cast (
    .dec_i  ( dec_q ),
    .cast_o ( cast  )
  );

  fcvt_round_select u_round_select (
    .cast_i ( cast  ),
    .rsp_o  ( rsp_d )
  );

  // Stage 1 drives the response
  fcvt_stage #(
    .payload_t ( fcvt_pkg::result_t )
  ) u_stage1 (
    .clk_i   ( clk_i       ),
    .rst_n_i ( rst_n_i     ),
    .valid_i ( s0_valid    ),
    .ready_o ( s0_ready    ),
    .data_i  ( rsp_d       ),
    .valid_o ( out_valid_o ),
    .ready_i ( out_ready_i ),
    .data_o  ( rsp_o       )
  );

  assign busy_o = s0_valid | out_valid_o;

endmodule
